//--- Makefile
VERILATOR ?= verilator
TOP ?= apbUartTb
RTL_TOP ?= apbUart
FLIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_TEXT ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- project.f
rtl/uartPkg.sv
rtl/uartBaudGen.sv
rtl/uartFifo.sv
rtl/uartTransmitter.sv
rtl/uartReceiver.sv
rtl/uartRegs.sv
rtl/apbUart.sv
testbench/apbUartTb.sv

//--- rtl/apbUart.sv
/*
 * APB UART top level
 * Register file, baud generator, FIFOs, transmitter and receiver
 */
`timescale 1ns/100ps
`default_nettype none

module apbUart #(
	parameter int FIFO_DEPTH = uartPkg::FIFO_DEPTH_DEFAULT
) (
	input logic CLK,
	input logic iRST,
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input uartPkg::regAddrT PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	input logic SIN,
	output logic SOUT
);
	import uartPkg::*;

	lcrT lcr;
	logic [2*DATA_W-1:0] divisor;
	logic tick;
	logic thrValid;
	logic [DATA_W-1:0] thrData;
	logic txValid;
	logic txReady;
	logic [DATA_W-1:0] txData;
	logic txBusy;
	rxEntryT rxFrame;
	logic rxFrameValid;
	rxEntryT rxHead;
	logic rxHeadValid;
	logic rxPop;
	logic rxFifoFull;

	// Zero wait state slave
	assign PREADY = 1'b1;
	assign PSLVERR = 1'b0;

	uartRegs uartRegs_inst (
		.CLK(CLK),
		.iRST(iRST),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PRDATA(PRDATA),
		.lcr(lcr),
		.divisor(divisor),
		.thrValid(thrValid),
		.thrData(thrData),
		.txFifoEmpty(!txValid),
		.txBusy(txBusy),
		.rxHead(rxHead),
		.rxHeadValid(rxHeadValid),
		.rxPop(rxPop),
		.rxFrameValid(rxFrameValid),
		.rxFifoFull(rxFifoFull)
	);

	uartBaudGen uartBaudGen_inst (
		.CLK(CLK),
		.iRST(iRST),
		.divisor(divisor),
		.tick(tick)
	);

	// Transmit path
	uartFifo #(.WIDTH(DATA_W), .DEPTH(FIFO_DEPTH)) txFifo_inst (
		.CLK(CLK),
		.iRST(iRST),
		.inValid(thrValid),
		.inReady(),
		.inData(thrData),
		.outValid(txValid),
		.outReady(txReady),
		.outData(txData),
		.full()
	);

	uartTransmitter uartTransmitter_inst (
		.CLK(CLK),
		.iRST(iRST),
		.tick(tick),
		.lcr(lcr),
		.inValid(txValid),
		.inReady(txReady),
		.inData(txData),
		.busy(txBusy),
		.SOUT(SOUT)
	);

	// Receive path
	uartReceiver uartReceiver_inst (
		.CLK(CLK),
		.iRST(iRST),
		.tick(tick),
		.lcr(lcr),
		.SIN(SIN),
		.outValid(rxFrameValid),
		.outData(rxFrame)
	);

	uartFifo #(.WIDTH($bits(rxEntryT)), .DEPTH(FIFO_DEPTH)) rxFifo_inst (
		.CLK(CLK),
		.iRST(iRST),
		.inValid(rxFrameValid),
		.inReady(),
		.inData(rxFrame),
		.outValid(rxHeadValid),
		.outReady(rxPop),
		.outData(rxHead),
		.full(rxFifoFull)
	);

endmodule

`default_nettype wire

//--- rtl/uartBaudGen.sv
/*
 * Baud generator
 * One tick every divisor clocks, sixteen ticks per bit
 */
`timescale 1ns/100ps
`default_nettype none

module uartBaudGen (
	input logic CLK,
	input logic iRST,
	input logic [2*uartPkg::DATA_W-1:0] divisor,
	output logic tick
);
	import uartPkg::*;

	logic [2*DATA_W-1:0] count;

	// Divisors 0 and 1 keep the counter at its end, so tick every clock
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (count <= 1)
		begin
			count <= divisor;
			tick <= 1'b1;
		end
		else
		begin
			count <= count - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/uartFifo.sv
/*
 * Synchronous FIFO with valid/ready on both sides
 * Head entry is visible on outData without a read delay
 */
`timescale 1ns/100ps
`default_nettype none

module uartFifo #(
	parameter int WIDTH = uartPkg::DATA_W,
	parameter int DEPTH = uartPkg::FIFO_DEPTH_DEFAULT
) (
	input logic CLK,
	input logic iRST,
	input logic inValid,
	output logic inReady,
	input logic [WIDTH-1:0] inData,
	output logic outValid,
	input logic outReady,
	output logic [WIDTH-1:0] outData,
	output logic full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign full = (count == CNT_W'(DEPTH));
	assign inReady = !full;
	assign outValid = (count != '0);
	assign outData = mem[rdPtr];
	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	always_ff @(posedge CLK)
	begin
		if (push)
			mem[wrPtr] <= inData;
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			// Usage only moves when exactly one side transfers
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/uartPkg.sv
/*
 * UART package
 * Register map, register layouts and reset values shared by the APB UART
 */
`default_nettype none

package uartPkg;

	localparam int DATA_W = 8;
	localparam int FIFO_DEPTH_DEFAULT = 16;

	// Register offsets on the APB bus
	typedef enum logic [2:0] {
		ADDR_RBR = 3'd0,
		ADDR_IER = 3'd1,
		ADDR_IIR = 3'd2,
		ADDR_LCR = 3'd3,
		ADDR_MCR = 3'd4,
		ADDR_LSR = 3'd5,
		ADDR_MSR = 3'd6,
		ADDR_SCR = 3'd7
	} regAddrT;

	typedef struct packed {
		logic dlab;
		logic brk;
		logic stick;
		logic eps;
		logic pen;
		logic stb;
		logic [1:0] wls;
	} lcrT;

	typedef struct packed {
		logic fifoErr;
		logic temt;
		logic thre;
		logic bi;
		logic fe;
		logic pe;
		logic oe;
		logic dr;
	} lsrT;

	// One received character with its error flags
	typedef struct packed {
		logic fe;
		logic pe;
		logic [DATA_W-1:0] data;
	} rxEntryT;

	localparam lcrT LCR_RESET = '0;
	localparam logic [DATA_W-1:0] SCR_RESET = '0;
	localparam logic [2*DATA_W-1:0] DIV_RESET = 16'd1;

endpackage

`default_nettype wire

//--- rtl/uartReceiver.sv
/*
 * UART receiver
 * Synchronizes SIN, samples each bit at its middle, checks parity and stop bit
 */
`timescale 1ns/100ps
`default_nettype none

module uartReceiver (
	input logic CLK,
	input logic iRST,
	input logic tick,
	input uartPkg::lcrT lcr,
	input logic SIN,
	output logic outValid,
	output uartPkg::rxEntryT outData
);
	import uartPkg::*;

	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rxStateT;

	rxStateT state;
	logic sinMeta;
	logic sinSync;
	logic [3:0] tickCnt;
	logic [2:0] bitCnt;
	logic [DATA_W-1:0] shiftReg;
	logic parity;
	logic parityErr;
	logic sample;

	// Counter wraps every 16 ticks, so after the start check it hits mid-bit
	assign sample = tick && (tickCnt == 4'd15);

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			sinMeta <= 1'b1;
			sinSync <= 1'b1;
			state <= RX_IDLE;
			tickCnt <= '0;
			bitCnt <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			sinMeta <= SIN;
			sinSync <= sinMeta;
			outValid <= 1'b0;
			if (tick)
				tickCnt <= tickCnt + 1'b1;
			case (state)
				RX_IDLE:
				begin
					// Eight ticks from here lands in the middle of the start bit
					if (tick && !sinSync)
					begin
						state <= RX_START;
						tickCnt <= 4'd8;
					end
				end
				RX_START:
				begin
					if (sample)
					begin
						state <= sinSync ? RX_IDLE : RX_DATA;
						bitCnt <= '0;
					end
				end
				RX_DATA:
				begin
					if (sample)
					begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'(lcr.wls) + 3'd4)
							state <= lcr.pen ? RX_PARITY : RX_STOP;
					end
				end
				RX_PARITY:
				begin
					if (sample)
						state <= RX_STOP;
				end
				RX_STOP:
				begin
					if (sample)
					begin
						state <= RX_IDLE;
						outValid <= 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == RX_START && sample)
		begin
			parity <= 1'b0;
			parityErr <= 1'b0;
		end
		// Bits enter at the top and move down towards bit 0
		if (state == RX_DATA && sample)
		begin
			shiftReg <= {sinSync, shiftReg[DATA_W-1:1]};
			parity <= parity ^ sinSync;
		end
		if (state == RX_PARITY && sample)
			parityErr <= lcr.eps ? (parity ^ sinSync) : !(parity ^ sinSync);
		if (state == RX_STOP && sample)
		begin
			outData.fe <= !sinSync;
			outData.pe <= parityErr;
			// Right-align short words with zeros above them
			outData.data <= shiftReg >> (2'd3 - lcr.wls);
		end
	end

endmodule

`default_nettype wire

//--- rtl/uartRegs.sv
/*
 * UART register file
 * APB decode, LCR/DLL/DLM/SCR storage, line status and read data
 */
`timescale 1ns/100ps
`default_nettype none

module uartRegs (
	input logic CLK,
	input logic iRST,
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input uartPkg::regAddrT PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output uartPkg::lcrT lcr,
	output logic [2*uartPkg::DATA_W-1:0] divisor,
	output logic thrValid,
	output logic [uartPkg::DATA_W-1:0] thrData,
	input logic txFifoEmpty,
	input logic txBusy,
	input uartPkg::rxEntryT rxHead,
	input logic rxHeadValid,
	output logic rxPop,
	input logic rxFrameValid,
	input logic rxFifoFull
);
	import uartPkg::*;

	logic wrEn;
	logic rdEn;
	logic lsrRead;
	logic [DATA_W-1:0] dll;
	logic [DATA_W-1:0] dlm;
	logic [DATA_W-1:0] scr;
	logic [DATA_W-1:0] rdByte;
	logic overrun;
	lsrT lsr;

	// Access phase of a zero wait state transfer
	assign wrEn = PSEL && PENABLE && PWRITE;
	assign rdEn = PSEL && PENABLE && !PWRITE;

	assign thrValid = wrEn && (PADDR == ADDR_RBR) && !lcr.dlab;
	assign thrData = PWDATA[DATA_W-1:0];
	assign rxPop = rdEn && (PADDR == ADDR_RBR) && !lcr.dlab;
	assign lsrRead = rdEn && (PADDR == ADDR_LSR);
	assign divisor = {dlm, dll};

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			lcr <= LCR_RESET;
			dll <= DIV_RESET[DATA_W-1:0];
			dlm <= DIV_RESET[2*DATA_W-1:DATA_W];
			scr <= SCR_RESET;
		end
		else if (wrEn)
		begin
			case (PADDR)
				ADDR_RBR:
				begin
					if (lcr.dlab)
						dll <= PWDATA[DATA_W-1:0];
				end
				ADDR_IER:
				begin
					if (lcr.dlab)
						dlm <= PWDATA[DATA_W-1:0];
				end
				ADDR_LCR: lcr <= lcrT'(PWDATA[7:0]);
				ADDR_SCR: scr <= PWDATA[DATA_W-1:0];
				default: ;
			endcase
		end
	end

	// A lost frame wins over a clearing LSR read
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
			overrun <= 1'b0;
		else if (rxFrameValid && rxFifoFull)
			overrun <= 1'b1;
		else if (lsrRead)
			overrun <= 1'b0;
	end

	always_comb
	begin
		lsr.fifoErr = 1'b0;
		lsr.temt = txFifoEmpty && !txBusy;
		lsr.thre = txFifoEmpty;
		lsr.bi = 1'b0;
		// Error flags belong to the character at the FIFO head
		lsr.fe = rxHeadValid && rxHead.fe;
		lsr.pe = rxHeadValid && rxHead.pe;
		lsr.oe = overrun;
		lsr.dr = rxHeadValid;
	end

	always_comb
	begin
		case (PADDR)
			ADDR_RBR: rdByte = lcr.dlab ? dll : rxHead.data;
			ADDR_IER: rdByte = lcr.dlab ? dlm : '0;
			ADDR_LCR: rdByte = lcr;
			ADDR_LSR: rdByte = lsr;
			ADDR_SCR: rdByte = scr;
			ADDR_IIR, ADDR_MCR, ADDR_MSR: rdByte = '0;
			default: rdByte = '0;
		endcase
	end

	assign PRDATA = {{(32-DATA_W){1'b0}}, rdByte};

endmodule

`default_nettype wire

//--- rtl/uartTransmitter.sv
/*
 * UART transmitter
 * Start bit, 5 to 8 data bits LSB first, optional parity, 1 or 2 stop bits
 */
`timescale 1ns/100ps
`default_nettype none

module uartTransmitter (
	input logic CLK,
	input logic iRST,
	input logic tick,
	input uartPkg::lcrT lcr,
	input logic inValid,
	output logic inReady,
	input logic [uartPkg::DATA_W-1:0] inData,
	output logic busy,
	output logic SOUT
);
	import uartPkg::*;

	typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} txStateT;

	txStateT state;
	logic [3:0] tickCnt;
	logic [2:0] bitCnt;
	logic [DATA_W-1:0] shiftReg;
	logic parity;
	logic bitEnd;
	logic lineBit;

	// Accept only on a tick so the start bit lasts a full 16 ticks
	assign inReady = (state == TX_IDLE) && tick;
	assign busy = (state != TX_IDLE);
	assign bitEnd = tick && (tickCnt == 4'd15);

	always_comb
	begin
		case (state)
			TX_START: lineBit = 1'b0;
			TX_DATA: lineBit = shiftReg[0];
			TX_PARITY: lineBit = lcr.eps ? parity : !parity;
			default: lineBit = 1'b1;
		endcase
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= TX_IDLE;
			tickCnt <= '0;
			bitCnt <= '0;
			SOUT <= 1'b1;
		end
		else
		begin
			SOUT <= lineBit;
			if (tick)
				tickCnt <= tickCnt + 1'b1;
			case (state)
				TX_IDLE:
				begin
					if (inValid && inReady)
					begin
						state <= TX_START;
						tickCnt <= '0;
					end
				end
				TX_START:
				begin
					if (bitEnd)
					begin
						state <= TX_DATA;
						bitCnt <= '0;
					end
				end
				TX_DATA:
				begin
					if (bitEnd)
					begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'(lcr.wls) + 3'd4)
						begin
							state <= lcr.pen ? TX_PARITY : TX_STOP;
							bitCnt <= '0;
						end
					end
				end
				TX_PARITY:
				begin
					if (bitEnd)
						state <= TX_STOP;
				end
				TX_STOP:
				begin
					// Second stop bit when stb is set
					if (bitEnd)
					begin
						if (lcr.stb && bitCnt == '0)
							bitCnt <= 3'd1;
						else
							state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Character shift register and running parity
	always_ff @(posedge CLK)
	begin
		if (inValid && inReady)
			shiftReg <= inData;
		else if (state == TX_DATA && bitEnd)
			shiftReg <= shiftReg >> 1;
		if (state == TX_START)
			parity <= 1'b0;
		else if (state == TX_DATA && bitEnd)
			parity <= parity ^ shiftReg[0];
	end

endmodule

`default_nettype wire

//--- testbench/apbUartTb.sv
/*
 * Testbench for the APB UART
 * APB tasks, serial driver and SOUT sampler, reference functions and checks
 */
`timescale 1ns/100ps
`default_nettype none

module apbUartTb;
	import uartPkg::*;

	localparam int DEPTH = FIFO_DEPTH_DEFAULT;
	localparam int DIV = 2;
	localparam int BIT_CLKS = 16 * DIV;
	localparam int BIT_NS = BIT_CLKS * 20;
	localparam int NTX = 8;
	localparam int NRX = 12;
	// Twice the line time of all frames at 12 bits each, plus setup time
	localparam int FRAMES = NTX + NRX + 3 + DEPTH + 1;
	localparam int WATCHDOG_NS = FRAMES * 12 * BIT_NS * 2 + 1000 * 20;

	logic CLK;
	logic iRST;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	regAddrT PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic SIN;
	logic SOUT;

	int errCount = 0;
	int checkCount = 0;
	int testErrStart = 0;
	int txChecked = 0;
	int rxSent = 0;
	lcrT txLcr;
	logic [7:0] txExpQ[$];
	logic [11:0] rxBitsQ[$];
	int rxLenQ[$];

	apbUart #(.FIFO_DEPTH(DEPTH)) apbUart_inst (
		.CLK(CLK),
		.iRST(iRST),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.PSLVERR(PSLVERR),
		.SIN(SIN),
		.SOUT(SOUT)
	);

	always #10 CLK = ~CLK;

	// Line bits in send order with the start bit in bit 0 and idle high above
	function automatic logic [11:0] refFrame(lcrT l, logic [7:0] c);
		logic [11:0] f;
		int n;
		logic par;
		f = '1;
		n = int'(l.wls) + 5;
		par = 1'b0;
		f[0] = 1'b0;
		for (int i = 0; i < n; i++)
		begin
			f[1 + i] = c[i];
			par = par ^ c[i];
		end
		if (l.pen)
			f[1 + n] = l.eps ? par : !par;
		return f;
	endfunction

	function automatic int frameLen(lcrT l);
		return 1 + int'(l.wls) + 5 + (l.pen ? 1 : 0) + (l.stb ? 2 : 1);
	endfunction

	function automatic logic [7:0] refChar(lcrT l, logic [7:0] c);
		return c & (8'hff >> (2'd3 - l.wls));
	endfunction

	function automatic lsrT refLsr(logic dr, logic oe, logic pe, logic fe, logic thre,
		logic temt);
		lsrT s;
		s = '0;
		s.dr = dr;
		s.oe = oe;
		s.pe = pe;
		s.fe = fe;
		s.thre = thre;
		s.temt = temt;
		return s;
	endfunction

	task automatic checkByte(string name, logic [7:0] exp, logic [7:0] got);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("FAIL %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic checkLsr(lsrT exp, lsrT got);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("FAIL LSR expected %h got %h", exp, got);
		end
	endtask

	task automatic checkFrameBit(int idx, logic exp, logic got);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("FAIL SOUT bit %0d expected %h got %h", idx, exp, got);
		end
	endtask

	task automatic checkFlag(string name, logic exp, logic got);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("FAIL %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic apbWrite(regAddrT a, logic [7:0] d);
		@(negedge CLK);
		PSEL = 1'b1;
		PWRITE = 1'b1;
		PADDR = a;
		PWDATA = {24'h0, d};
		PENABLE = 1'b0;
		@(negedge CLK);
		PENABLE = 1'b1;
		#5;
		checkFlag("PREADY", 1'b1, PREADY);
		checkFlag("PSLVERR", 1'b0, PSLVERR);
		@(negedge CLK);
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
	endtask

	task automatic apbRead(regAddrT a, output logic [7:0] d);
		@(negedge CLK);
		PSEL = 1'b1;
		PWRITE = 1'b0;
		PADDR = a;
		PENABLE = 1'b0;
		@(negedge CLK);
		PENABLE = 1'b1;
		// Sample halfway between the clock edges of the access phase
		#5;
		d = PRDATA[7:0];
		checkFlag("PREADY", 1'b1, PREADY);
		checkFlag("PSLVERR", 1'b0, PSLVERR);
		@(negedge CLK);
		PSEL = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic readLsr(output lsrT s);
		logic [7:0] d;
		apbRead(ADDR_LSR, d);
		s = lsrT'(d);
	endtask

	task automatic queueFrame(lcrT l, logic [7:0] c, logic badPar, logic badStop);
		logic [11:0] f;
		int n;
		f = refFrame(l, c);
		n = int'(l.wls) + 5;
		if (badPar)
			f[1 + n] = !f[1 + n];
		if (badStop)
			f[1 + n + (l.pen ? 1 : 0)] = 1'b0;
		rxBitsQ.push_back(f);
		rxLenQ.push_back(frameLen(l));
	endtask

	task automatic endTest(string name);
		$display("test %s: %0d errors", name, errCount - testErrStart);
		testErrStart = errCount;
	endtask

	function automatic lcrT randomLcr();
		lcrT l;
		l = '0;
		l.wls = 2'($urandom);
		l.stb = 1'($urandom);
		l.pen = 1'($urandom);
		l.eps = 1'($urandom);
		return l;
	endfunction

	// Serial driver holds each bit for 16 x divisor clocks and adds two idle bits
	initial
	begin
		logic [11:0] f;
		int n;
		@(negedge iRST);
		forever
		begin
			while (rxBitsQ.size() == 0)
				@(negedge CLK);
			f = rxBitsQ.pop_front();
			n = rxLenQ.pop_front();
			@(negedge CLK);
			for (int i = 0; i < n + 2; i++)
			begin
				SIN = (i < n) ? f[i] : 1'b1;
				repeat (BIT_CLKS) @(negedge CLK);
			end
			rxSent++;
		end
	end

	// SOUT sampler checks each bit at its middle against refFrame
	initial
	begin
		logic [11:0] exp;
		int n;
		logic [7:0] c;
		@(negedge iRST);
		forever
		begin
			@(negedge SOUT);
			if (txExpQ.size() == 0)
			begin
				errCount++;
				$display("start bit on SOUT with no character written");
			end
			else
			begin
				c = txExpQ.pop_front();
				exp = refFrame(txLcr, c);
				n = frameLen(txLcr);
				#(BIT_NS / 2 + 10);
				for (int i = 0; i < n; i++)
				begin
					checkFrameBit(i, exp[i], SOUT);
					if (i < n - 1)
						#(BIT_NS);
				end
				txChecked++;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout, the tests did not finish in time");
		$display("sim failed");
		$finish;
	end

	task automatic testReset();
		logic [7:0] d;
		lsrT s;
		apbRead(ADDR_LCR, d);
		checkByte("LCR", 8'h00, d);
		apbRead(ADDR_SCR, d);
		checkByte("SCR", 8'h00, d);
		apbWrite(ADDR_LCR, 8'h80);
		apbRead(ADDR_RBR, d);
		checkByte("DLL", DIV_RESET[7:0], d);
		apbRead(ADDR_IER, d);
		checkByte("DLM", DIV_RESET[15:8], d);
		apbWrite(ADDR_LCR, 8'h00);
		readLsr(s);
		checkLsr(refLsr(0, 0, 0, 0, 1, 1), s);
		endTest("reset values");
	endtask

	// Writes follow closely so the baud counter never loads the large divisor
	task automatic testDivisor();
		logic [7:0] d;
		apbWrite(ADDR_LCR, 8'h80);
		apbWrite(ADDR_RBR, 8'h5a);
		apbWrite(ADDR_IER, 8'hc3);
		apbWrite(ADDR_SCR, 8'ha5);
		apbRead(ADDR_RBR, d);
		checkByte("DLL", 8'h5a, d);
		apbRead(ADDR_IER, d);
		checkByte("DLM", 8'hc3, d);
		// DLM is nonzero here, so IER must hide it once DLAB is clear
		apbWrite(ADDR_LCR, 8'h00);
		apbRead(ADDR_IER, d);
		checkByte("IER", 8'h00, d);
		apbRead(ADDR_SCR, d);
		checkByte("SCR", 8'ha5, d);
		apbRead(ADDR_LCR, d);
		checkByte("LCR", 8'h00, d);
		apbWrite(ADDR_LCR, 8'h80);
		apbWrite(ADDR_RBR, 8'(DIV));
		apbWrite(ADDR_IER, 8'h00);
		apbWrite(ADDR_LCR, 8'h00);
		endTest("divisor and scratch");
	endtask

	task automatic testTransmit();
		logic [7:0] c;
		logic [7:0] d;
		lsrT s;
		for (int i = 0; i < NTX; i++)
		begin
			txLcr = randomLcr();
			c = 8'($urandom);
			apbWrite(ADDR_LCR, txLcr);
			txExpQ.push_back(c);
			apbWrite(ADDR_RBR, c);
			wait (txChecked == i + 1);
			// The last stop bit has to leave the line before LCR changes again
			for (int k = 0; k < 200; k++)
			begin
				readLsr(s);
				if (s.temt)
					break;
			end
			checkLsr(refLsr(0, 0, 0, 0, 1, 1), s);
		end
		// THR writes above must not have reached DLL
		apbWrite(ADDR_LCR, 8'h80);
		apbRead(ADDR_RBR, d);
		checkByte("DLL", 8'(DIV), d);
		apbWrite(ADDR_LCR, 8'h00);
		endTest("transmit");
	endtask

	task automatic testReceive();
		lcrT l;
		logic [7:0] chars[4];
		logic [7:0] d;
		lsrT s;
		for (int k = 0; k < NRX / 4; k++)
		begin
			l = randomLcr();
			apbWrite(ADDR_LCR, l);
			for (int i = 0; i < 4; i++)
			begin
				chars[i] = 8'($urandom);
				queueFrame(l, chars[i], 1'b0, 1'b0);
			end
			wait (rxSent == (k + 1) * 4);
			for (int i = 0; i < 4; i++)
			begin
				readLsr(s);
				checkLsr(refLsr(1, 0, 0, 0, 1, 1), s);
				apbRead(ADDR_RBR, d);
				checkByte("RBR", refChar(l, chars[i]), d);
			end
			readLsr(s);
			checkLsr(refLsr(0, 0, 0, 0, 1, 1), s);
		end
		endTest("receive");
	endtask

	task automatic testLineErrors();
		lcrT l;
		logic [7:0] chars[3];
		logic [7:0] d;
		lsrT s;
		int base;
		l = '0;
		l.wls = 2'd3;
		l.pen = 1'b1;
		l.eps = 1'b1;
		base = rxSent;
		apbWrite(ADDR_LCR, l);
		for (int i = 0; i < 3; i++)
			chars[i] = 8'($urandom);
		queueFrame(l, chars[0], 1'b1, 1'b0);
		queueFrame(l, chars[1], 1'b0, 1'b1);
		queueFrame(l, chars[2], 1'b0, 1'b0);
		wait (rxSent == base + 3);
		readLsr(s);
		checkLsr(refLsr(1, 0, 1, 0, 1, 1), s);
		apbRead(ADDR_RBR, d);
		checkByte("RBR", chars[0], d);
		readLsr(s);
		checkLsr(refLsr(1, 0, 0, 1, 1, 1), s);
		apbRead(ADDR_RBR, d);
		checkByte("RBR", chars[1], d);
		readLsr(s);
		checkLsr(refLsr(1, 0, 0, 0, 1, 1), s);
		apbRead(ADDR_RBR, d);
		checkByte("RBR", chars[2], d);
		readLsr(s);
		checkLsr(refLsr(0, 0, 0, 0, 1, 1), s);
		endTest("line errors");
	endtask

	task automatic testOverrun();
		lcrT l;
		logic [7:0] chars[DEPTH + 1];
		logic [7:0] d;
		lsrT s;
		int base;
		l = '0;
		l.wls = 2'd3;
		base = rxSent;
		apbWrite(ADDR_LCR, l);
		for (int i = 0; i <= DEPTH; i++)
		begin
			chars[i] = 8'($urandom);
			queueFrame(l, chars[i], 1'b0, 1'b0);
		end
		wait (rxSent == base + DEPTH + 1);
		readLsr(s);
		checkLsr(refLsr(1, 1, 0, 0, 1, 1), s);
		readLsr(s);
		checkLsr(refLsr(1, 0, 0, 0, 1, 1), s);
		for (int i = 0; i < DEPTH; i++)
		begin
			apbRead(ADDR_RBR, d);
			checkByte("RBR", chars[i], d);
		end
		readLsr(s);
		checkLsr(refLsr(0, 0, 0, 0, 1, 1), s);
		endTest("overrun");
	endtask

	initial
	begin
		void'($urandom(32'h9e5));
		CLK = 1'b0;
		iRST = 1'b1;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = ADDR_RBR;
		PWDATA = '0;
		SIN = 1'b1;
		txLcr = '0;
		repeat (8) @(negedge CLK);
		iRST = 1'b0;
		testReset();
		testDivisor();
		testTransmit();
		testReceive();
		testLineErrors();
		testOverrun();
		$display("checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
